//--- filelist.f
verilog/armPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/controller.sv
verilog/hazardUnit.sv
verilog/datapath.sv
verilog/armCore.sv
verif/armCoreTb.sv

//--- verif/armCoreTb.sv
module armCoreTb
  import armPkg::*;
;

  // ==============================
  // Setup
  // ==============================
  localparam logic [31:0] ResetPc = 32'h20;
  localparam int MemWords = 64;
  localparam int Timeout = 200;
  localparam int SettleCycles = 12;

  // Condition fields
  localparam logic [3:0] Al = 4'hE;
  localparam logic [3:0] Eq = 4'h0;
  localparam logic [3:0] Ne = 4'h1;

  // Data processing opcodes
  localparam logic [3:0] OpcAnd = 4'h0;
  localparam logic [3:0] OpcSub = 4'h2;
  localparam logic [3:0] OpcAdd = 4'h4;
  localparam logic [3:0] OpcOrr = 4'hC;
  localparam logic [3:0] OpcMov = 4'hD;

  // B to itself, parks the core after a program
  localparam logic [31:0] HaltWord = 32'hEAFF_FFFE;

  logic        clk;
  logic        rst;
  logic [31:0] pcF;
  logic [31:0] instrF;
  logic [31:0] aluOutM;
  logic [31:0] writeDataM;
  logic        memWriteM;
  logic [31:0] readDataM;

  logic [31:0] imem [0:MemWords-1];
  logic [31:0] dmem [0:MemWords-1];
  logic [31:0] prog [$];
  logic [31:0] storeAddr [$];
  logic [31:0] storeData [$];
  int          errors;
  int          checks;

  armCore #(.ResetPc(ResetPc)) i_armCore (
    .clk        (clk),
    .rst        (rst),
    .pcF        (pcF),
    .instrF     (instrF),
    .aluOutM    (aluOutM),
    .writeDataM (writeDataM),
    .memWriteM  (memWriteM),
    .readDataM  (readDataM)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Both memories answer in the same cycle
  assign instrF    = imem[pcF[7:2]];
  assign readDataM = dmem[aluOutM[7:2]];

  // Store port, every write also logged
  always @(posedge clk) begin
    if (memWriteM) begin
      dmem[aluOutM[7:2]] <= writeDataM;
      storeAddr.push_back(aluOutM);
      storeData.push_back(writeDataM);
    end
  end

  // ==============================
  // Encoders
  // ==============================
  function automatic logic [31:0] dpImm(input logic [3:0] cond, input logic [3:0] opc,
                                        input logic s, input logic [3:0] rn,
                                        input logic [3:0] rd, input logic [3:0] rot,
                                        input logic [7:0] imm8);
    return {cond, 2'b00, 1'b1, opc, s, rn, rd, rot, imm8};
  endfunction

  function automatic logic [31:0] dpReg(input logic [3:0] cond, input logic [3:0] opc,
                                        input logic s, input logic [3:0] rn,
                                        input logic [3:0] rd, input logic [3:0] rm);
    return {cond, 2'b00, 1'b0, opc, s, rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed, offset added, no writeback
  function automatic logic [31:0] memWord(input logic load, input logic [3:0] rn,
                                          input logic [3:0] rd, input logic [11:0] imm12);
    return {4'hE, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, imm12};
  endfunction

  function automatic logic [31:0] branchWord(input logic [3:0] cond, input logic [23:0] off);
    return {cond, 2'b10, 1'b1, 1'b0, off};
  endfunction

  // Expected value of a rotated immediate, right rotate by twice rot
  function automatic logic [31:0] rotImm(input logic [7:0] imm8, input logic [3:0] rot);
    logic [31:0] w;
    int          n;
    w = {24'h0, imm8};
    n = 2 * rot;
    if (n == 0) begin
      return w;
    end
    return (w >> n) | (w << (32 - n));
  endfunction

  // ==============================
  // Helpers
  // ==============================
  task automatic clearMemories();
    int i;
    for (i = 0; i < MemWords; i++) begin
      imem[i] = HaltWord;
      // Fill tied to the full byte address
      dmem[i] = 32'hDA7A_0000 | (i << 2);
    end
  endtask

  // Load prog at ResetPc, reset, then wait for the expected stores
  task automatic runProgram(input string name, input int nStores);
    int i;
    int cycles;
    @(negedge clk);
    rst = 1'b1;
    clearMemories();
    for (i = 0; i < prog.size(); i++) begin
      imem[ResetPc[7:2] + i] = prog[i];
    end
    storeAddr.delete();
    storeData.delete();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    while ((storeAddr.size() < nStores) && (cycles < Timeout)) begin
      @(negedge clk);
      cycles++;
    end
    if (storeAddr.size() < nStores) begin
      errors++;
      $display("%s: timed out after %0d cycles with %0d of %0d stores seen",
               name, cycles, storeAddr.size(), nStores);
    end
    // Extra cycles to catch stray stores
    repeat (SettleCycles) @(negedge clk);
    checks++;
    if (storeAddr.size() != nStores) begin
      errors++;
      $display("FAILED %s store count: expected %0d, actual %0d",
               name, nStores, storeAddr.size());
    end
    prog.delete();
  endtask

  task automatic checkStore(input string name, input int idx,
                            input logic [31:0] expAddr, input logic [31:0] expData);
    checks++;
    if (idx >= storeAddr.size()) begin
      errors++;
      $display("%s: store %0d never happened", name, idx);
    end else begin
      if (storeAddr[idx] !== expAddr) begin
        errors++;
        $display("FAILED %s addr %0d: expected %h, actual %h",
                 name, idx, expAddr, storeAddr[idx]);
      end
      if (storeData[idx] !== expData) begin
        errors++;
        $display("FAILED %s data %0d: expected %h, actual %h",
                 name, idx, expData, storeData[idx]);
      end
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic resetState();
    @(negedge clk);
    rst = 1'b1;
    clearMemories();
    repeat (3) @(negedge clk);
    checks++;
    if (pcF !== ResetPc) begin
      errors++;
      $display("FAILED resetState pcF: expected %h, actual %h", ResetPc, pcF);
    end
    if (memWriteM !== 1'b0) begin
      errors++;
      $display("FAILED resetState memWriteM: expected %b, actual %b", 1'b0, memWriteM);
    end
    rst = 1'b0;
  endtask

  task automatic checkAluOps();
    logic [7:0]  i1;
    logic [7:0]  i2;
    logic [3:0]  r1;
    logic [3:0]  r2;
    logic [31:0] a;
    logic [31:0] b;
    i1 = $urandom;
    i2 = $urandom;
    r1 = $urandom;
    r2 = $urandom;
    a = rotImm(i1, r1);
    b = rotImm(i2, r2);
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd1, r1, i1));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd2, r2, i2));
    prog.push_back(dpReg(Al, OpcAdd, 1'b0, 4'd1, 4'd3, 4'd2));
    prog.push_back(dpReg(Al, OpcSub, 1'b0, 4'd1, 4'd4, 4'd2));
    prog.push_back(dpReg(Al, OpcAnd, 1'b0, 4'd1, 4'd5, 4'd2));
    prog.push_back(dpReg(Al, OpcOrr, 1'b0, 4'd1, 4'd6, 4'd2));
    prog.push_back(memWord(1'b0, 4'd0, 4'd1, 12'h000));
    prog.push_back(memWord(1'b0, 4'd0, 4'd2, 12'h004));
    prog.push_back(memWord(1'b0, 4'd0, 4'd3, 12'h008));
    prog.push_back(memWord(1'b0, 4'd0, 4'd4, 12'h00C));
    prog.push_back(memWord(1'b0, 4'd0, 4'd5, 12'h010));
    prog.push_back(memWord(1'b0, 4'd0, 4'd6, 12'h014));
    runProgram("aluOps", 6);
    checkStore("aluOps mov1", 0, 32'h00, a);
    checkStore("aluOps mov2", 1, 32'h04, b);
    checkStore("aluOps add", 2, 32'h08, a + b);
    checkStore("aluOps sub", 3, 32'h0C, a - b);
    checkStore("aluOps and", 4, 32'h10, a & b);
    checkStore("aluOps orr", 5, 32'h14, a | b);
  endtask

  task automatic chainForwarding();
    logic [7:0]  k0;
    logic [7:0]  k1;
    logic [7:0]  k2;
    logic [31:0] sum;
    logic [31:0] r2;
    k0 = $urandom;
    k1 = $urandom;
    k2 = $urandom;
    // Running value of R1, then R2 from R1 twice and once more
    sum = 32'(k0) + 32'(k1) + 32'(k2);
    r2 = sum + sum;
    r2 = r2 + sum;
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd1, 4'd0, k0));
    prog.push_back(dpImm(Al, OpcAdd, 1'b0, 4'd1, 4'd1, 4'd0, k1));
    prog.push_back(dpImm(Al, OpcAdd, 1'b0, 4'd1, 4'd1, 4'd0, k2));
    prog.push_back(dpReg(Al, OpcAdd, 1'b0, 4'd1, 4'd2, 4'd1));
    prog.push_back(dpReg(Al, OpcAdd, 1'b0, 4'd2, 4'd2, 4'd1));
    prog.push_back(memWord(1'b0, 4'd0, 4'd2, 12'h018));
    runProgram("forwarding", 1);
    checkStore("forwarding", 0, 32'h18, r2);
  endtask

  task automatic loadThenUse();
    logic [31:0] w;
    logic [7:0]  addend;
    w = $urandom;
    addend = $urandom;
    // Word built a byte at a time with rotated immediates
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd1, 4'd0, w[7:0]));
    prog.push_back(dpImm(Al, OpcOrr, 1'b0, 4'd1, 4'd1, 4'd12, w[15:8]));
    prog.push_back(dpImm(Al, OpcOrr, 1'b0, 4'd1, 4'd1, 4'd8, w[23:16]));
    prog.push_back(dpImm(Al, OpcOrr, 1'b0, 4'd1, 4'd1, 4'd4, w[31:24]));
    prog.push_back(memWord(1'b0, 4'd0, 4'd1, 12'h020));
    prog.push_back(memWord(1'b1, 4'd0, 4'd3, 12'h020));
    // Uses the load result at once
    prog.push_back(dpImm(Al, OpcAdd, 1'b0, 4'd3, 4'd4, 4'd0, addend));
    prog.push_back(memWord(1'b0, 4'd0, 4'd4, 12'h024));
    runProgram("loadUse", 2);
    checkStore("loadUse word", 0, 32'h20, w);
    checkStore("loadUse sum", 1, 32'h24, w + 32'(addend));
  endtask

  task automatic condExecution(input logic equal);
    logic [7:0]  x;
    logic [7:0]  y;
    logic [7:0]  base;
    logic [31:0] expected;
    x = $urandom;
    // Offset of 1 to 255 keeps y away from x
    y = x + 8'd1 + 8'($urandom % 255);
    base = $urandom;
    expected = equal ? 32'(base) + 32'd1 : 32'(base) + 32'd2;
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd1, 4'd0, x));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd2, 4'd0, equal ? x : y));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd5, 4'd0, base));
    prog.push_back(dpReg(Al, OpcSub, 1'b1, 4'd1, 4'd3, 4'd2));
    prog.push_back(dpImm(Eq, OpcAdd, 1'b0, 4'd5, 4'd5, 4'd0, 8'd1));
    prog.push_back(dpImm(Ne, OpcAdd, 1'b0, 4'd5, 4'd5, 4'd0, 8'd2));
    prog.push_back(memWord(1'b0, 4'd0, 4'd5, 12'h030));
    if (equal) begin
      runProgram("condEqual", 1);
      checkStore("condEqual", 0, 32'h30, expected);
    end else begin
      runProgram("condUnequal", 1);
      checkStore("condUnequal", 0, 32'h30, expected);
    end
  endtask

  task automatic branchSkip();
    logic [7:0] v;
    v = $urandom;
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd1, 4'd0, v));
    // Target is PC+8 plus two words, past the next three
    prog.push_back(branchWord(Al, 24'd2));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd1, 4'd0, ~v));
    prog.push_back(dpImm(Al, OpcMov, 1'b0, 4'd0, 4'd1, 4'd0, ~v ^ 8'h01));
    prog.push_back(memWord(1'b0, 4'd0, 4'd1, 12'h044));
    prog.push_back(memWord(1'b0, 4'd0, 4'd1, 12'h040));
    runProgram("branch", 1);
    checkStore("branch", 0, 32'h40, 32'(v));
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    void'($urandom(90));
    rst = 1'b1;
    errors = 0;
    checks = 0;
    clearMemories();
    resetState();
    checkAluOps();
    chainForwarding();
    loadThenUse();
    condExecution(1'b1);
    condExecution(1'b0);
    branchSkip();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- verilog/alu.sv
module alu
  import armPkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOpT       aluOp,
  output logic [31:0] result,
  output flagsT       flags
);

  logic        isSub;
  logic        isArith;
  logic [31:0] bEff;
  logic [32:0] sum;

  assign isSub   = (aluOp == AluSub);
  assign isArith = (aluOp == AluAdd) || isSub;

  // Subtract as a plus inverted b plus one
  assign bEff = isSub ? ~b : b;
  assign sum  = {1'b0, a} + {1'b0, bEff} + {32'd0, isSub};

  always_comb begin
    case (aluOp)
      AluAdd:  result = sum[31:0];
      AluSub:  result = sum[31:0];
      AluAnd:  result = a & b;
      AluOrr:  result = a | b;
      default: result = b;
    endcase
  end

  assign flags.n = result[31];
  assign flags.z = (result == 32'd0);
  // Carry out, which is not-borrow for SUB
  assign flags.c = isArith & sum[32];
  // Operands of equal sign giving a result of other sign
  assign flags.v = isArith & (a[31] == bEff[31]) & (sum[31] != a[31]);

endmodule

//--- verilog/armCore.sv
module armCore
  import armPkg::*;
#(
  parameter logic [31:0] ResetPc = 32'h0
) (
  input  logic        clk,
  input  logic        rst,
  // Instruction port
  output logic [31:0] pcF,
  input  logic [31:0] instrF,
  // Data port
  output logic [31:0] aluOutM,
  output logic [31:0] writeDataM,
  output logic        memWriteM,
  input  logic [31:0] readDataM
);

  instrT  instrD;
  flagsT  aluFlagsE;
  ctrlT   ctrlE;
  ctrlT   ctrlM;
  ctrlT   ctrlW;
  logic   branchTakenE;
  hazardT hazard;
  matchT  match;

  // Store strobe comes straight from the M stage control word
  assign memWriteM = ctrlM.memWrite;

  controller i_controller (
    .clk          (clk),
    .rst          (rst),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .hazard       (hazard),
    .ctrlE        (ctrlE),
    .ctrlM        (ctrlM),
    .ctrlW        (ctrlW),
    .branchTakenE (branchTakenE)
  );

  datapath #(.ResetPc(ResetPc)) i_datapath (
    .clk          (clk),
    .rst          (rst),
    .instrF       (instrF),
    .readDataM    (readDataM),
    .ctrlE        (ctrlE),
    .ctrlM        (ctrlM),
    .ctrlW        (ctrlW),
    .branchTakenE (branchTakenE),
    .hazard       (hazard),
    .pcF          (pcF),
    .instrD       (instrD),
    .aluOutM      (aluOutM),
    .writeDataM   (writeDataM),
    .aluFlagsE    (aluFlagsE),
    .match        (match)
  );

  hazardUnit i_hazardUnit (
    .match        (match),
    .ctrlE        (ctrlE),
    .ctrlM        (ctrlM),
    .ctrlW        (ctrlW),
    .branchTakenE (branchTakenE),
    .hazard       (hazard)
  );

endmodule

//--- verilog/armPkg.sv
package armPkg;

  // ==============================
  // Instruction word formats
  // ==============================

  // Operand 2 as rotated immediate
  typedef struct packed {
    logic [3:0] rotate;
    logic [7:0] imm8;
  } dpImmT;

  // Operand 2 as register, shift field ignored by this core
  typedef struct packed {
    logic [7:0] shift;
    logic [3:0] rm;
  } dpRegT;

  typedef union packed {
    dpImmT immOp;
    dpRegT regOp;
  } operand2T;

  // Data processing
  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] op;
    logic       i;
    logic [3:0] opcode;
    logic       s;
    logic [3:0] rn;
    logic [3:0] rd;
    operand2T   src2;
  } dpFmtT;

  // Word load and store
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        i;
    logic        p;
    logic        u;
    logic        b;
    logic        w;
    logic        l;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] imm12;
  } memFmtT;

  // Branch
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  op;
    logic        i;
    logic        link;
    logic [23:0] imm24;
  } brFmtT;

  typedef union packed {
    dpFmtT  dpFmt;
    memFmtT memFmt;
    brFmtT  brFmt;
  } instrT;

  // Format field values
  localparam logic [1:0] OpDp  = 2'b00;
  localparam logic [1:0] OpMem = 2'b01;
  localparam logic [1:0] OpBr  = 2'b10;

  // Condition field values
  localparam logic [3:0] CondEq = 4'b0000;
  localparam logic [3:0] CondNe = 4'b0001;
  localparam logic [3:0] CondAl = 4'b1110;

  // Data processing opcodes
  localparam logic [3:0] DpAnd = 4'b0000;
  localparam logic [3:0] DpSub = 4'b0010;
  localparam logic [3:0] DpAdd = 4'b0100;
  localparam logic [3:0] DpOrr = 4'b1100;
  localparam logic [3:0] DpMov = 4'b1101;

  // Never-execute word used as a D stage bubble
  localparam logic [31:0] BubbleInstr = 32'hF000_0000;

  // ==============================
  // Control and hazard words
  // ==============================

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOrr,
    AluMov
  } aluOpT;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memToReg;
    logic       aluSrcImm;
    logic       setFlags;
    logic       branch;
    aluOpT      aluOp;
    logic [3:0] cond;
  } ctrlT;

  // Forward select: 0 register file, 1 writeback, 2 memory stage
  typedef struct packed {
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    logic       stallF;
    logic       stallD;
    logic       flushD;
    logic       flushE;
  } hazardT;

  typedef struct packed {
    logic match1EM;
    logic match1EW;
    logic match2EM;
    logic match2EW;
    logic match12DE;
  } matchT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

endpackage

//--- verilog/controller.sv
module controller
  import armPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  instrT  instrD,
  input  flagsT  aluFlagsE,
  input  hazardT hazard,
  output ctrlT   ctrlE,
  output ctrlT   ctrlM,
  output ctrlT   ctrlW,
  output logic   branchTakenE
);

  ctrlT  ctrlD;
  ctrlT  ctrlRegE;
  flagsT flags;
  logic  condExE;

  // ==============================
  // Decode
  // ==============================
  always_comb begin
    ctrlD = '0;
    ctrlD.cond = instrD.dpFmt.cond;
    case (instrD.dpFmt.op)
      OpDp: begin
        ctrlD.regWrite  = 1'b1;
        ctrlD.aluSrcImm = instrD.dpFmt.i;
        ctrlD.setFlags  = instrD.dpFmt.s;
        case (instrD.dpFmt.opcode)
          DpAdd:   ctrlD.aluOp = AluAdd;
          DpSub:   ctrlD.aluOp = AluSub;
          DpAnd:   ctrlD.aluOp = AluAnd;
          DpOrr:   ctrlD.aluOp = AluOrr;
          DpMov:   ctrlD.aluOp = AluMov;
          // Unsupported opcode runs as a bubble
          default: ctrlD = '0;
        endcase
      end
      OpMem: begin
        // Address is Rn plus or minus imm12
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.aluOp     = instrD.memFmt.u ? AluAdd : AluSub;
        if (instrD.memFmt.l) begin
          ctrlD.regWrite = 1'b1;
          ctrlD.memToReg = 1'b1;
        end else begin
          ctrlD.memWrite = 1'b1;
        end
      end
      OpBr: begin
        // Target is PC+8 plus the word offset
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.aluOp     = AluAdd;
        ctrlD.branch    = 1'b1;
      end
      default: ctrlD = '0;
    endcase
  end

  // ==============================
  // Execute
  // ==============================
  always_ff @(posedge clk) begin
    if (rst || hazard.flushE) begin
      ctrlRegE <= '0;
    end else begin
      ctrlRegE <= ctrlD;
    end
  end

  // Only EQ, NE and AL can pass
  always_comb begin
    case (ctrlRegE.cond)
      CondEq:  condExE = flags.z;
      CondNe:  condExE = ~flags.z;
      CondAl:  condExE = 1'b1;
      default: condExE = 1'b0;
    endcase
  end

  // Failed condition drops every side effect
  always_comb begin
    ctrlE = ctrlRegE;
    if (!condExE) begin
      ctrlE.regWrite = 1'b0;
      ctrlE.memWrite = 1'b0;
      ctrlE.setFlags = 1'b0;
      ctrlE.branch   = 1'b0;
    end
  end

  assign branchTakenE = ctrlE.branch;

  // NZCV written at the end of E
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (ctrlE.setFlags) begin
      flags <= aluFlagsE;
    end
  end

  // Gated control carried into M and W
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      ctrlM <= ctrlE;
      ctrlW <= ctrlM;
    end
  end

endmodule

//--- verilog/datapath.sv
module datapath
  import armPkg::*;
#(
  parameter logic [31:0] ResetPc = 32'h0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] instrF,
  input  logic [31:0] readDataM,
  input  ctrlT        ctrlE,
  input  ctrlT        ctrlM,
  input  ctrlT        ctrlW,
  input  logic        branchTakenE,
  input  hazardT      hazard,
  output logic [31:0] pcF,
  output instrT       instrD,
  output logic [31:0] aluOutM,
  output logic [31:0] writeDataM,
  output flagsT       aluFlagsE,
  output matchT       match
);

  logic [31:0] pcPlus4F;
  logic [31:0] pcNextF;
  logic [3:0]  ra1D;
  logic [3:0]  ra2D;
  logic [3:0]  wa3D;
  logic [31:0] rd1D;
  logic [31:0] rd2D;
  logic [63:0] rotWideD;
  logic [31:0] immD;
  logic [3:0]  ra1E;
  logic [3:0]  ra2E;
  logic [3:0]  wa3E;
  logic [31:0] rd1E;
  logic [31:0] rd2E;
  logic [31:0] immE;
  logic [31:0] srcAE;
  logic [31:0] srcBE;
  logic [31:0] writeDataE;
  logic [31:0] aluResultE;
  logic [3:0]  wa3M;
  logic [3:0]  wa3W;
  logic [31:0] aluOutW;
  logic [31:0] readDataW;
  logic [31:0] resultW;

  // Operand bypass from W or M
  function automatic logic [31:0] fwdMux(input logic [1:0] sel, input logic [31:0] rf,
                                         input logic [31:0] wb, input logic [31:0] mem);
    case (sel)
      2'd1:    return wb;
      2'd2:    return mem;
      default: return rf;
    endcase
  endfunction

  // ==============================
  // Fetch
  // ==============================
  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= ResetPc;
    end else if (!hazard.stallF) begin
      pcF <= pcNextF;
    end
  end

  // ==============================
  // Decode
  // ==============================
  always_ff @(posedge clk) begin
    if (rst || hazard.flushD) begin
      instrD <= BubbleInstr;
    end else if (!hazard.stallD) begin
      instrD <= instrF;
    end
  end

  // Branch reads R15, store reads Rd as data
  assign ra1D = (instrD.brFmt.op == OpBr) ? 4'd15 : instrD.dpFmt.rn;
  assign ra2D = (instrD.memFmt.op == OpMem) ? instrD.memFmt.rd : instrD.dpFmt.src2.regOp.rm;
  assign wa3D = instrD.dpFmt.rd;

  // PC of the D instruction plus 8 is the current fetch PC plus 4
  regFile i_regFile (
    .clk     (clk),
    .we      (ctrlW.regWrite),
    .ra1     (ra1D),
    .ra2     (ra2D),
    .wa3     (wa3W),
    .wd3     (resultW),
    .pcPlus8 (pcPlus4F),
    .rd1     (rd1D),
    .rd2     (rd2D)
  );

  // Rotate right by twice the rotate field
  assign rotWideD = {2{{24'h0, instrD.dpFmt.src2.immOp.imm8}}} >>
                    {instrD.dpFmt.src2.immOp.rotate, 1'b0};

  always_comb begin
    case (instrD.dpFmt.op)
      OpMem:   immD = {20'h0, instrD.memFmt.imm12};
      OpBr:    immD = {{6{instrD.brFmt.imm24[23]}}, instrD.brFmt.imm24, 2'b00};
      default: immD = rotWideD[31:0];
    endcase
  end

  // ==============================
  // Execute
  // ==============================
  always_ff @(posedge clk) begin
    rd1E <= rd1D;
    rd2E <= rd2D;
    immE <= immD;
    ra1E <= ra1D;
    ra2E <= ra2D;
    wa3E <= wa3D;
  end

  assign srcAE      = fwdMux(hazard.fwdA, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(hazard.fwdB, rd2E, resultW, aluOutM);
  assign srcBE      = ctrlE.aluSrcImm ? immE : writeDataE;

  alu i_alu (
    .a      (srcAE),
    .b      (srcBE),
    .aluOp  (ctrlE.aluOp),
    .result (aluResultE),
    .flags  (aluFlagsE)
  );

  // Memory and writeback
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    wa3M       <= wa3E;
    aluOutW    <= aluOutM;
    wa3W       <= wa3M;
    // Load data captured only for loads
    if (ctrlM.memToReg) begin
      readDataW <= readDataM;
    end
  end

  assign resultW = ctrlW.memToReg ? readDataW : aluOutW;

  // Address compares for the hazard unit
  assign match.match1EM  = (ra1E == wa3M);
  assign match.match1EW  = (ra1E == wa3W);
  assign match.match2EM  = (ra2E == wa3M);
  assign match.match2EW  = (ra2E == wa3W);
  assign match.match12DE = (ra1D == wa3E) || (ra2D == wa3E);

endmodule

//--- verilog/hazardUnit.sv
module hazardUnit
  import armPkg::*;
(
  input  matchT  match,
  input  ctrlT   ctrlE,
  input  ctrlT   ctrlM,
  input  ctrlT   ctrlW,
  input  logic   branchTakenE,
  output hazardT hazard
);

  logic ldStall;

  // M stage wins over W, it holds the newer value
  function automatic logic [1:0] fwdSel(input logic matchM, input logic wrM,
                                        input logic matchW, input logic wrW);
    if (matchM && wrM) begin
      return 2'd2;
    end else if (matchW && wrW) begin
      return 2'd1;
    end
    return 2'd0;
  endfunction

  // ==============================
  // Forwarding
  // ==============================
  assign hazard.fwdA = fwdSel(match.match1EM, ctrlM.regWrite, match.match1EW, ctrlW.regWrite);
  assign hazard.fwdB = fwdSel(match.match2EM, ctrlM.regWrite, match.match2EW, ctrlW.regWrite);

  // ==============================
  // Stall and flush
  // ==============================

  // Load in E feeding the instruction in D
  assign ldStall = match.match12DE && ctrlE.memToReg;

  assign hazard.stallF = ldStall;
  assign hazard.stallD = ldStall;

  // Taken branch drops the two younger instructions
  assign hazard.flushD = branchTakenE;
  // Bubble into E on a stall
  assign hazard.flushE = ldStall || branchTakenE;

endmodule

//--- verilog/regFile.sv
module regFile (
  input  logic        clk,
  input  logic        we,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa3,
  input  logic [31:0] wd3,
  input  logic [31:0] pcPlus8,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  // R0 to R14, R15 is not stored
  logic [31:0] regs [0:14];

  always_ff @(posedge clk) begin
    if (we && (wa3 != 4'd15)) begin
      regs[wa3] <= wd3;
    end
  end

  // R15 first, then write-through of the W result
  function automatic logic [31:0] readPort(input logic [3:0] ra);
    if (ra == 4'd15) begin
      return pcPlus8;
    end else if (we && (ra == wa3)) begin
      return wd3;
    end
    return regs[ra];
  endfunction

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

endmodule
